//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --assert --timescale 1ns/10ps -j 0
TOP       ?= rfnoc_backend_tb
FILELIST  ?= rfnoc_backend.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

# The run exits with a failing status when the testbench calls $$fatal
test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- include/backend_defines.svh
`ifndef BACKEND_DEFINES_SVH
`define BACKEND_DEFINES_SVH

// Data port counts
`define NUM_DATA_I          2
`define NUM_DATA_O          2
`define NUM_FLUSH_PORTS     (`NUM_DATA_I + `NUM_DATA_O)

// Minimum soft-reset pulse, in rfnoc_chdr_clk cycles
`define RESET_LENGTH        32

// Block description reported in the status word
`define BACKEND_PROTO_VER   6'd1
`define NOC_ID              32'hB10C_0A17
`define CTRL_FIFOSIZE       6'd5
`define CTRL_MAX_ASYNC_MSGS 8'd4
`define MTU                 6'd10
`define CTRL_CLK_IDX        6'd1
`define TB_CLK_IDX          6'd2

// Width of the core config and status words
`define CORE_WORD_W         512

`endif

//--- logic/backend_iface.sv
`timescale 1ns/10ps
`default_nettype none

`include "backend_defines.svh"

module backend_iface
  import backend_pkg::*;
(
  input  logic                    rfnoc_chdr_clk,
  input  logic                    rst,
  input  logic [`CORE_WORD_W-1:0] rfnoc_core_config,
  output logic [`CORE_WORD_W-1:0] rfnoc_core_status,
  output logic                    rfnoc_chdr_rst,
  output logic                    rfnoc_ctrl_rst,
  flush_if.ctrl                   flush [`NUM_FLUSH_PORTS]
);

  // Stretch counter width, loads RESET_LENGTH-1
  localparam int RST_CNT_W = $clog2(`RESET_LENGTH);
  localparam logic [RST_CNT_W-1:0] RST_LOAD = RST_CNT_W'(`RESET_LENGTH - 1);

  // --------------------------------------------------------------------
  // Config word decode
  // --------------------------------------------------------------------

  backend_config_t cfg_q;
  logic            flush_en_q;
  flush_timeout_t  flush_timeout_q;

  // Capture stage, only the used low bits
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rst) begin
      cfg_q <= '0;
    end else begin
      cfg_q <= backend_config_t'(rfnoc_core_config[CONFIG_USED_W-1:0]);
    end
  end

  // Second stage where the control-domain synchronizer would sit
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rst) begin
      flush_en_q      <= 1'b0;
      flush_timeout_q <= '0;
    end else begin
      flush_en_q      <= cfg_q.flush_en;
      flush_timeout_q <= cfg_q.flush_timeout;
    end
  end

  // --------------------------------------------------------------------
  // Soft resets
  // --------------------------------------------------------------------

  // Bit 1 is the CHDR reset, bit 0 the control reset
  logic [1:0]           soft_rst_cur;
  logic [1:0]           soft_rst_prev;
  logic [1:0]           soft_rst_edge;
  logic [1:0]           rst_stretch;
  logic [RST_CNT_W-1:0] rst_cnt [2];

  assign soft_rst_cur = {cfg_q.soft_chdr_rst, cfg_q.soft_ctrl_rst};

  // Rising edge only, a held level gives one pulse
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rst) begin
      soft_rst_prev <= 2'b00;
      soft_rst_edge <= 2'b00;
    end else begin
      soft_rst_prev <= soft_rst_cur;
      soft_rst_edge <= soft_rst_cur & ~soft_rst_prev;
    end
  end

  // Stretch each edge to RESET_LENGTH cycles
  // A new edge reloads the counter and extends the pulse
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rst) begin
      rst_stretch <= 2'b00;
      rst_cnt     <= '{default: '0};
    end else begin
      for (int r = 0; r < 2; r++) begin
        if (soft_rst_edge[r]) begin
          rst_cnt[r]     <= RST_LOAD;
          rst_stretch[r] <= 1'b1;
        end else if (rst_cnt[r] != '0) begin
          rst_cnt[r] <= rst_cnt[r] - 1'b1;
        end else begin
          rst_stretch[r] <= 1'b0;
        end
      end
    end
  end

  assign rfnoc_chdr_rst = rst_stretch[1];
  assign rfnoc_ctrl_rst = rst_stretch[0];

  // --------------------------------------------------------------------
  // Fan out to the ports and collect their levels
  // --------------------------------------------------------------------

  logic [`NUM_FLUSH_PORTS-1:0] active_vec;
  logic [`NUM_FLUSH_PORTS-1:0] done_vec;

  for (genvar i = 0; i < `NUM_FLUSH_PORTS; i++) begin : g_port
    assign flush[i].flush_en      = flush_en_q;
    assign flush[i].flush_timeout = flush_timeout_q;
    assign active_vec[i]          = flush[i].flush_active;
    assign done_vec[i]            = flush[i].flush_done;
  end

  // Active if any port drains, done only when all ports are done
  // Two stages, the second stands in for the status synchronizer
  logic flush_active_q1, flush_active_q2;
  logic flush_done_q1, flush_done_q2;

  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rst) begin
      flush_active_q1 <= 1'b0;
      flush_active_q2 <= 1'b0;
      flush_done_q1   <= 1'b0;
      flush_done_q2   <= 1'b0;
    end else begin
      flush_active_q1 <= |active_vec;
      flush_active_q2 <= flush_active_q1;
      flush_done_q1   <= &done_vec;
      flush_done_q2   <= flush_done_q1;
    end
  end

  // --------------------------------------------------------------------
  // Status word
  // --------------------------------------------------------------------

  backend_status_t status_s;

  always_comb begin
    status_s.proto_ver           = `BACKEND_PROTO_VER;
    status_s.num_data_i          = 6'(`NUM_DATA_I);
    status_s.num_data_o          = 6'(`NUM_DATA_O);
    status_s.ctrl_fifosize       = `CTRL_FIFOSIZE;
    status_s.ctrl_max_async_msgs = `CTRL_MAX_ASYNC_MSGS;
    status_s.noc_id              = `NOC_ID;
    status_s.mtu                 = `MTU;
    status_s.ctrl_clk_idx        = `CTRL_CLK_IDX;
    status_s.tb_clk_idx          = `TB_CLK_IDX;
    status_s.flush_active        = flush_active_q2;
    status_s.flush_done          = flush_done_q2;
  end

  // Upper bits are zero
  assign rfnoc_core_status = {{(`CORE_WORD_W - STATUS_USED_W){1'b0}}, status_s};

endmodule

`default_nettype wire

//--- logic/backend_pkg.sv
`default_nettype none

package backend_pkg;

  // Flush timeout in rfnoc_chdr_clk cycles
  typedef logic [31:0] flush_timeout_t;

  // Low part of the core config word, flush_en sits in bit 0
  typedef struct packed {
    logic           soft_chdr_rst;
    logic           soft_ctrl_rst;
    flush_timeout_t flush_timeout;
    logic           flush_en;
  } backend_config_t;

  // Low part of the core status word
  // Declared MSB first, proto_ver lands in bits 5:0
  typedef struct packed {
    logic        flush_done;
    logic        flush_active;
    logic [5:0]  tb_clk_idx;
    logic [5:0]  ctrl_clk_idx;
    logic [5:0]  mtu;
    logic [31:0] noc_id;
    logic [7:0]  ctrl_max_async_msgs;
    logic [5:0]  ctrl_fifosize;
    logic [5:0]  num_data_o;
    logic [5:0]  num_data_i;
    logic [5:0]  proto_ver;
  } backend_status_t;

  // Used widths of the two words
  // Config bits above this are ignored, status bits above are zero
  localparam int CONFIG_USED_W = $bits(backend_config_t);
  localparam int STATUS_USED_W = $bits(backend_status_t);

endpackage

`default_nettype wire

//--- logic/data_port_flush.sv
`timescale 1ns/10ps
`default_nettype none

module data_port_flush
  import flush_pkg::*;
(
  input  logic   rfnoc_chdr_clk,
  input  logic   rst,
  flush_if.port  flush,
  input  logic   port_valid_in,
  output logic   port_valid_out
);

  flush_state_t state;
  logic [31:0]  idle_cnt;
  logic         valid_q;

  // --------------------------------------------------------------------
  // Flush FSM
  // --------------------------------------------------------------------

  // Idle counter counts quiet cycles while draining
  // Any beat on the port restarts the count
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rst) begin
      state    <= FLUSH_IDLE;
      idle_cnt <= '0;
    end else begin
      case (state)
        FLUSH_IDLE: begin
          if (flush.flush_en) begin
            state    <= FLUSH_DRAIN;
            idle_cnt <= '0;
          end
        end
        FLUSH_DRAIN: begin
          if (!flush.flush_en) begin
            state <= FLUSH_IDLE;
          end else if (idle_cnt >= flush.flush_timeout) begin
            // Quiet long enough
            state <= FLUSH_DONE;
          end else if (port_valid_in) begin
            idle_cnt <= '0;
          end else begin
            idle_cnt <= idle_cnt + 32'd1;
          end
        end
        FLUSH_DONE: begin
          // Hold until software drops the enable
          if (!flush.flush_en) begin
            state <= FLUSH_IDLE;
          end
        end
        default: begin
          state <= FLUSH_IDLE;
        end
      endcase
    end
  end

  assign flush.flush_active = (state == FLUSH_DRAIN);
  assign flush.flush_done   = (state == FLUSH_DONE);

  // --------------------------------------------------------------------
  // Traffic gate
  // --------------------------------------------------------------------

  // One register stage on the strobe
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= port_valid_in;
    end
  end

  // Beats are dropped outside FLUSH_IDLE
  assign port_valid_out = valid_q & (state == FLUSH_IDLE);

endmodule

`default_nettype wire

//--- logic/flush_if.sv
`timescale 1ns/10ps
`default_nettype none

// One port's flush control and status
interface flush_if
  import backend_pkg::*;
();

  // Control, levels from the backend
  logic           flush_en;
  flush_timeout_t flush_timeout;

  // Status, levels from the port unit
  logic           flush_active;
  logic           flush_done;

  // Backend side
  modport ctrl (output flush_en, output flush_timeout,
                input  flush_active, input flush_done);

  // Port unit side
  modport port (input  flush_en, input flush_timeout,
                output flush_active, output flush_done);

endinterface

`default_nettype wire

//--- logic/flush_pkg.sv
`default_nettype none

package flush_pkg;

  // Per-port flush state
  // FLUSH_IDLE   traffic passes through
  // FLUSH_DRAIN  traffic dropped, waiting for the port to go quiet
  // FLUSH_DONE   port quiet for the timeout, held until flush_en drops
  typedef enum logic [1:0] {
    FLUSH_IDLE  = 2'd0,
    FLUSH_DRAIN = 2'd1,
    FLUSH_DONE  = 2'd2
  } flush_state_t;

endpackage

`default_nettype wire

//--- logic/rfnoc_backend_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "backend_defines.svh"

module rfnoc_backend_top (
  input  logic                        rfnoc_chdr_clk,
  input  logic                        rst,
  input  logic [`CORE_WORD_W-1:0]     rfnoc_core_config,
  output logic [`CORE_WORD_W-1:0]     rfnoc_core_status,
  output logic                        rfnoc_chdr_rst,
  output logic                        rfnoc_ctrl_rst,
  input  logic [`NUM_FLUSH_PORTS-1:0] port_valid_in,
  output logic [`NUM_FLUSH_PORTS-1:0] port_valid_out
);

  // One flush bundle per data port
  flush_if flush_bus [`NUM_FLUSH_PORTS] ();

  // --------------------------------------------------------------------
  // Backend interface
  // --------------------------------------------------------------------

  backend_iface i_backend_iface (
    .rfnoc_chdr_clk    (rfnoc_chdr_clk),
    .rst               (rst),
    .rfnoc_core_config (rfnoc_core_config),
    .rfnoc_core_status (rfnoc_core_status),
    .rfnoc_chdr_rst    (rfnoc_chdr_rst),
    .rfnoc_ctrl_rst    (rfnoc_ctrl_rst),
    .flush             (flush_bus)
  );

  // --------------------------------------------------------------------
  // Per-port flush units
  // --------------------------------------------------------------------

  // Indices below NUM_DATA_I are input ports
  // The rest are output ports
  for (genvar p = 0; p < `NUM_FLUSH_PORTS; p++) begin : g_flush
    data_port_flush i_data_port_flush (
      .rfnoc_chdr_clk (rfnoc_chdr_clk),
      .rst            (rst),
      .flush          (flush_bus[p]),
      .port_valid_in  (port_valid_in[p]),
      .port_valid_out (port_valid_out[p])
    );
  end

endmodule

`default_nettype wire

//--- rfnoc_backend.f
+incdir+include
logic/backend_pkg.sv
logic/flush_pkg.sv
logic/flush_if.sv
logic/data_port_flush.sv
logic/backend_iface.sv
logic/rfnoc_backend_top.sv
tests/rfnoc_backend_checker.sv
tests/rfnoc_backend_tb.sv

//--- tests/rfnoc_backend_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "backend_defines.svh"

module rfnoc_backend_checker
  import backend_pkg::*;
(
  input logic                        rfnoc_chdr_clk,
  input logic                        rst,
  input logic [`CORE_WORD_W-1:0]     rfnoc_core_status,
  input logic                        rfnoc_chdr_rst,
  input logic [`NUM_FLUSH_PORTS-1:0] port_valid_out
);

  backend_status_t status_s;
  logic [7:0]      chdr_hi_cnt;

  assign status_s = backend_status_t'(rfnoc_core_status[STATUS_USED_W-1:0]);

  // Consecutive cycles with rfnoc_chdr_rst high, saturating
  always_ff @(posedge rfnoc_chdr_clk) begin
    if (rst || !rfnoc_chdr_rst) begin
      chdr_hi_cnt <= '0;
    end else if (chdr_hi_cnt != 8'hFF) begin
      chdr_hi_cnt <= chdr_hi_cnt + 8'd1;
    end
  end

  // --------------------------------------------------------------------
  // Properties
  // --------------------------------------------------------------------

  // Aggregate done only ever rises straight out of a drain
  a_done_after_active: assert property (@(posedge rfnoc_chdr_clk) disable iff (rst)
    $rose(status_s.flush_done) |-> $past(status_s.flush_active))
    else $error("aggregate flush_done rose without flush_active before it");

  // Pulse length counted at the falling edge
  a_chdr_rst_len: assert property (@(posedge rfnoc_chdr_clk) disable iff (rst)
    $fell(rfnoc_chdr_rst) |-> (chdr_hi_cnt >= 8'(`RESET_LENGTH)))
    else $error("rfnoc_chdr_rst pulse shorter than the reset length");

  // No beat leaves a port while the status shows a flush in progress
  a_no_valid_in_flush: assert property (@(posedge rfnoc_chdr_clk) disable iff (rst)
    status_s.flush_active |-> (port_valid_out == '0))
    else $error("port_valid_out set while flush_active");

endmodule

bind rfnoc_backend_top rfnoc_backend_checker i_rfnoc_backend_checker (
  .rfnoc_chdr_clk    (rfnoc_chdr_clk),
  .rst               (rst),
  .rfnoc_core_status (rfnoc_core_status),
  .rfnoc_chdr_rst    (rfnoc_chdr_rst),
  .port_valid_out    (port_valid_out)
);

`default_nettype wire

//--- tests/rfnoc_backend_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "backend_defines.svh"

module rfnoc_backend_tb
  import backend_pkg::*;
();

  localparam int NP       = `NUM_FLUSH_PORTS;
  localparam int SETTLE   = 4;
  localparam int NUM_ROWS = 10;

  // Loop step by which a cleared flush_en shows in the status
  localparam int CLEAR_AT = 6;

  // Traffic kinds
  localparam int TR_QUIET  = 0;
  localparam int TR_RANDOM = 1;
  localparam int TR_PORT0  = 2;

  // One step of the test table
  typedef struct {
    logic           flush_en;
    flush_timeout_t timeout;
    logic           soft_chdr;
    logic           soft_ctrl;
    int             traffic;
    int             hold;
    logic           zero_out;
    logic           done_low;
    logic           seen_active;
    logic           exp_active;
    logic           exp_done;
  } row_t;

  logic                    rfnoc_chdr_clk;
  logic                    rst;
  logic [`CORE_WORD_W-1:0] rfnoc_core_config;
  logic [`CORE_WORD_W-1:0] rfnoc_core_status;
  logic                    rfnoc_chdr_rst;
  logic                    rfnoc_ctrl_rst;
  logic [NP-1:0]           port_valid_in;
  logic [NP-1:0]           port_valid_out;

  row_t          rows [NUM_ROWS];
  integer        seed;
  logic [NP-1:0] prev_in;
  logic          prev_chdr;
  logic          prev_ctrl;

  rfnoc_backend_top i_rfnoc_backend_top (
    .rfnoc_chdr_clk    (rfnoc_chdr_clk),
    .rst               (rst),
    .rfnoc_core_config (rfnoc_core_config),
    .rfnoc_core_status (rfnoc_core_status),
    .rfnoc_chdr_rst    (rfnoc_chdr_rst),
    .rfnoc_ctrl_rst    (rfnoc_ctrl_rst),
    .port_valid_in     (port_valid_in),
    .port_valid_out    (port_valid_out)
  );

  // 20 ns clock
  initial begin
    rfnoc_chdr_clk = 1'b0;
    forever #10 rfnoc_chdr_clk = ~rfnoc_chdr_clk;
  end

  // --------------------------------------------------------------------
  // Helpers and compare tasks
  // --------------------------------------------------------------------

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_status(input string name, input backend_status_t exp,
                              input backend_status_t act);
    if (act !== exp) begin
      abort_run($sformatf("error: time %0t %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  task automatic check_valid(input string name, input logic [NP-1:0] exp,
                             input logic [NP-1:0] act);
    if (act !== exp) begin
      abort_run($sformatf("error: time %0t %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("error: time %0t %s expected %b got %b", $time, name, exp, act));
    end
  endtask

  function automatic backend_status_t read_status();
    return backend_status_t'(rfnoc_core_status[STATUS_USED_W-1:0]);
  endfunction

  // Status word as the block description defines it
  function automatic backend_status_t expected_status(input logic active, input logic done);
    backend_status_t s;
    s.proto_ver           = `BACKEND_PROTO_VER;
    s.num_data_i          = 6'(`NUM_DATA_I);
    s.num_data_o          = 6'(`NUM_DATA_O);
    s.ctrl_fifosize       = `CTRL_FIFOSIZE;
    s.ctrl_max_async_msgs = `CTRL_MAX_ASYNC_MSGS;
    s.noc_id              = `NOC_ID;
    s.mtu                 = `MTU;
    s.ctrl_clk_idx        = `CTRL_CLK_IDX;
    s.tb_clk_idx          = `TB_CLK_IDX;
    s.flush_active        = active;
    s.flush_done          = done;
    return s;
  endfunction

  // Used fields plus the zero upper part
  task automatic check_status_word(input backend_status_t exp);
    if (rfnoc_core_status[`CORE_WORD_W-1:STATUS_USED_W] !== '0) begin
      abort_run($sformatf("error: time %0t rfnoc_core_status upper bits expected 0 got %h",
                          $time, rfnoc_core_status[`CORE_WORD_W-1:STATUS_USED_W]));
    end
    check_status("rfnoc_core_status", exp, read_status());
  endtask

  function automatic logic [NP-1:0] traffic(input int kind);
    logic [NP-1:0] p;
    p = '0;
    if (kind == TR_RANDOM) begin
      p = NP'($random(seed));
    end else if (kind == TR_PORT0) begin
      p[0] = 1'b1;
    end
    return p;
  endfunction

  // Columns: flush_en, timeout, soft_chdr, soft_ctrl, traffic, hold,
  // zero_out, done_low, seen_active, exp_active, exp_done
  task automatic load_table();
    rows[0] = '{1'b0, 32'd0,  1'b0, 1'b0, TR_RANDOM, 40, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    rows[1] = '{1'b1, 32'd10, 1'b0, 1'b0, TR_QUIET,  4,  1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
    rows[2] = '{1'b0, 32'd0,  1'b0, 1'b0, TR_QUIET,  4,  1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    rows[3] = '{1'b0, 32'd0,  1'b0, 1'b0, TR_RANDOM, 30, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    rows[4] = '{1'b1, 32'd20, 1'b0, 1'b0, TR_PORT0,  60, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1};
    rows[5] = '{1'b0, 32'd0,  1'b0, 1'b0, TR_QUIET,  4,  1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    // Soft resets, the held CHDR bit in row 7 must not pulse again
    rows[6] = '{1'b0, 32'd0,  1'b1, 1'b0, TR_QUIET,  36, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    rows[7] = '{1'b0, 32'd0,  1'b1, 1'b1, TR_QUIET,  36, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    rows[8] = '{1'b0, 32'd0,  1'b0, 1'b0, TR_QUIET,  4,  1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    rows[9] = '{1'b0, 32'd0,  1'b0, 1'b0, TR_RANDOM, 20, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
  endtask

  // --------------------------------------------------------------------
  // Row runner
  // --------------------------------------------------------------------

  task automatic run_row(input int idx);
    row_t            r;
    backend_config_t cfg;
    backend_status_t st;
    logic [NP-1:0]   pat;
    logic            chdr_edge;
    logic            ctrl_edge;
    logic            rst_win;
    logic            seen;
    logic            reached;
    int              n;
    r         = rows[idx];
    cfg       = '{r.soft_chdr, r.soft_ctrl, r.timeout, r.flush_en};
    chdr_edge = r.soft_chdr & ~prev_chdr;
    ctrl_edge = r.soft_ctrl & ~prev_ctrl;
    seen      = 1'b0;
    // Quiet settle cycles let the config reach the units before traffic
    for (int i = 0; i < SETTLE + r.hold; i++) begin
      @(posedge rfnoc_chdr_clk);
      pat = (i < SETTLE) ? '0 : traffic(r.traffic);
      port_valid_in     <= pat;
      // Upper config bits set to show they are ignored
      rfnoc_core_config <= {{(`CORE_WORD_W - CONFIG_USED_W){1'b1}}, cfg};
      @(negedge rfnoc_chdr_clk);
      // Reset output high from cycle 3 for the reset length
      rst_win = (i >= 3) && (i < 3 + `RESET_LENGTH);
      check_bit("rfnoc_chdr_rst", chdr_edge & rst_win, rfnoc_chdr_rst);
      check_bit("rfnoc_ctrl_rst", ctrl_edge & rst_win, rfnoc_ctrl_rst);
      // Passthrough is the input one cycle back
      check_valid("port_valid_out", r.zero_out ? '0 : prev_in, port_valid_out);
      st = read_status();
      if (r.done_low) begin
        check_bit("flush_done", 1'b0, st.flush_done);
      end
      // Flush bits clear soon after the enable drops
      if (!r.flush_en && (i >= CLEAR_AT)) begin
        check_bit("flush_active", 1'b0, st.flush_active);
        check_bit("flush_done", 1'b0, st.flush_done);
      end
      seen |= st.flush_active;
      prev_in = pat;
    end
    // Inputs quiet, wait for the flush bits to settle
    @(posedge rfnoc_chdr_clk);
    port_valid_in <= '0;
    prev_in = '0;
    reached = 1'b0;
    n       = 0;
    while (!reached && (n < r.timeout + 32'd8)) begin
      @(negedge rfnoc_chdr_clk);
      st = read_status();
      seen |= st.flush_active;
      reached = (st.flush_active == r.exp_active) && (st.flush_done == r.exp_done);
      n++;
    end
    if (!reached) begin
      abort_run($sformatf("flush status did not reach its expected value in row %0d", idx));
    end
    if (r.seen_active && !seen) begin
      abort_run($sformatf("flush_active never went high in row %0d", idx));
    end
    check_status_word(expected_status(r.exp_active, r.exp_done));
    prev_chdr = r.soft_chdr;
    prev_ctrl = r.soft_ctrl;
  endtask

  // --------------------------------------------------------------------
  // Main sequence and watchdog
  // --------------------------------------------------------------------

  initial begin
    seed              = 9275;
    prev_in           = '0;
    prev_chdr         = 1'b0;
    prev_ctrl         = 1'b0;
    rst               = 1'b1;
    rfnoc_core_config = '0;
    port_valid_in     = '0;
    load_table();
    repeat (16) @(posedge rfnoc_chdr_clk);
    rst <= 1'b0;
    // State straight after reset
    @(negedge rfnoc_chdr_clk);
    check_status_word(expected_status(1'b0, 1'b0));
    check_valid("port_valid_out", '0, port_valid_out);
    check_bit("rfnoc_chdr_rst", 1'b0, rfnoc_chdr_rst);
    check_bit("rfnoc_ctrl_rst", 1'b0, rfnoc_ctrl_rst);
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    $display("=== PASS ===");
    $finish;
  end

  // Budget per row is the longest timeout plus 64 cycles
  initial begin
    flush_timeout_t max_to;
    @(posedge rfnoc_chdr_clk);
    max_to = '0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (rows[r].timeout > max_to) begin
        max_to = rows[r].timeout;
      end
    end
    repeat (NUM_ROWS * (max_to + 32'd64)) @(posedge rfnoc_chdr_clk);
    abort_run("timeout: the test sequence did not finish in time");
  end

endmodule

`default_nettype wire
